// ==== Bender.yml ====
package:
  name: lin_input_ctrl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/lin_pkg.sv
      - rtl/lin_burst_issuer.sv
      - rtl/lin_fetch_seq.sv
      - rtl/lin_sync_fifo.sv
      - rtl/lin_input_ctrl_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - verification/lin_input_ctrl_checker.sv
      - verification/tb_lin_input_ctrl.sv

// ==== rtl/lin_burst_issuer.sv ====
// AXI read address issuer
`timescale 1ns/1ps
`include "lin_params.svh"

module lin_burst_issuer (
    input  logic                      ACLK,
    input  logic                      ARESETn,
    input  logic                      linear_init,
    input  logic                      burst_go,
    input  lin_pkg::rd_cmd_t          cmd,
    input  lin_pkg::burst_len_t       input_leng,
    input  logic [`LIN_VEC_FIFO_AW:0] vec_room,
    input  logic                      axi_arready,
    output lin_pkg::axi_id_t          axi_arid,
    output lin_pkg::addr_t            axi_araddr,
    output lin_pkg::burst_len_t       axi_arlen,
    output logic [2:0]                axi_arsize,
    output logic [1:0]                axi_arburst,
    output logic                      axi_arvalid,
    output logic                      ar_done
);
    import lin_pkg::*;

    localparam logic [1:0] BURST_INCR = 2'b01;

    cnt_t       rem_m1;      // beats left in line minus one
    burst_len_t next_len;
    logic       pend;        // request waiting for ARREADY
    logic       pend_bias;   // pending request is a bias word

    // ------------------------------------------------
    // burst length, clipped to the line remainder
    assign rem_m1 = cmd.beats_left - cnt_t'(1);

    always_comb begin
        if (cmd.is_bias) begin
            next_len = '0;
        end else if (rem_m1 > cnt_t'(input_leng)) begin
            next_len = input_leng;
        end else begin
            next_len = burst_len_t'(rem_m1);
        end
    end

    // ------------------------------------------------
    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            pend      <= 1'b0;
            pend_bias <= 1'b0;
            axi_arid  <= '0;
        end else if (linear_init) begin
            pend      <= 1'b0;
            pend_bias <= 1'b0;
            axi_arid  <= '0;
        end else if (burst_go) begin
            pend      <= 1'b1;
            pend_bias <= cmd.is_bias;
            axi_arid  <= axi_arid + axi_id_t'(1);   // new id per command
        end else if (ar_done) begin
            pend      <= 1'b0;
        end
    end

    // address and length captured per command
    always_ff @(posedge ACLK) begin
        if (burst_go) begin
            axi_araddr <= cmd.addr;
            axi_arlen  <= next_len;
        end
    end

    // vector bursts wait until the whole burst fits in the FIFO
    assign axi_arvalid = pend & (pend_bias | (vec_room > axi_arlen));
    assign ar_done     = axi_arvalid & axi_arready;

    assign axi_arsize  = 3'(`LIN_ARSIZE_WORD);
    assign axi_arburst = BURST_INCR;

endmodule

// ==== rtl/lin_fetch_seq.sv ====
// Bias and vector fetch sequencer
`timescale 1ns/1ps
`include "lin_params.svh"

module lin_fetch_seq (
    input  logic                ACLK,
    input  logic                ARESETn,
    input  logic                linear_init,
    input  logic                bias_go,
    input  logic                input_go,
    input  lin_pkg::addr_t      bias_address,
    input  lin_pkg::addr_t      input_address,
    input  lin_pkg::cnt_t       bias_size,
    input  lin_pkg::cnt_t       output_size,
    input  lin_pkg::cnt_t       input_size,
    input  lin_pkg::cnt_t       input_num,
    input  logic                ar_done,
    input  lin_pkg::data_t      axi_rdata,
    input  logic                axi_rlast,
    input  logic                axi_rvalid,
    input  logic                bias_wr_ready,
    input  logic                vec_wr_ready,
    output logic                linear_ready,
    output logic                bias_done,
    output logic                input_done,
    output logic                burst_go,
    output lin_pkg::rd_cmd_t    cmd,
    output logic                axi_rready,
    output logic                bias_wr_valid,
    output lin_pkg::fifo_word_t bias_wr,
    output logic                vec_wr_valid,
    output lin_pkg::fifo_word_t vec_wr
);
    import lin_pkg::*;

    localparam addr_t WORD_STEP = addr_t'(`LIN_WORD_BYTES);

    seq_state_t state;
    seq_state_t bias_next;     // bias fetch or zero insert
    logic       ready_q;
    logic       cmd_sent;      // burst_go already given in this state
    addr_t      bias_addr;
    addr_t      vec_addr;
    cnt_t       line_cnt;
    cnt_t       item_cnt;
    cnt_t       bias_cnt;
    logic       line_end;
    logic       more_lines;
    logic       vec_beat;

    assign bias_next  = (bias_size != '0) ? BIAS_CMD : BIAS_ZERO;
    assign line_end   = (item_cnt + cnt_t'(1)) == input_size;
    assign more_lines = (line_cnt + cnt_t'(1)) < input_num;
    assign vec_beat   = axi_rvalid & vec_wr_ready;

    // ------------------------------------------------
    // fetch state machine
    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            state      <= IDLE;
            ready_q    <= 1'b0;
            bias_done  <= 1'b0;
            input_done <= 1'b0;
            cmd_sent   <= 1'b0;
            bias_addr  <= '0;
            vec_addr   <= '0;
            line_cnt   <= '0;
            item_cnt   <= '0;
            bias_cnt   <= '0;
        end else if (linear_init) begin
            state      <= IDLE;
            ready_q    <= 1'b0;
            bias_done  <= 1'b0;
            input_done <= 1'b0;
            cmd_sent   <= 1'b0;
        end else begin
            if (ar_done) begin
                cmd_sent <= 1'b0;
            end else if (burst_go) begin
                cmd_sent <= 1'b1;
            end
            case (state)
                IDLE: begin
                    ready_q <= 1'b1;
                    state   <= READY;
                end
                READY: begin
                    if (bias_go && input_go) begin
                        bias_addr <= bias_address;
                        vec_addr  <= input_address;
                        line_cnt  <= '0;
                        item_cnt  <= '0;
                        bias_cnt  <= '0;
                        state     <= bias_next;
                    end
                end
                BIAS_CMD: if (ar_done) state <= BIAS_DATA;
                BIAS_DATA: begin
                    if (axi_rvalid && bias_wr_ready) begin
                        bias_cnt  <= bias_cnt + cnt_t'(1);
                        bias_addr <= bias_addr + WORD_STEP;   // next line's bias
                        state     <= VEC_CMD;
                    end
                end
                BIAS_ZERO: begin
                    if (bias_wr_ready) begin
                        bias_cnt <= bias_cnt + cnt_t'(1);
                        state    <= VEC_CMD;
                    end
                end
                VEC_CMD: if (ar_done) state <= VEC_DATA;
                VEC_DATA: begin
                    if (vec_beat) begin
                        vec_addr <= vec_addr + WORD_STEP;
                        item_cnt <= item_cnt + cnt_t'(1);
                        if (axi_rlast && line_end) begin
                            line_cnt <= line_cnt + cnt_t'(1);
                            if (more_lines) begin
                                vec_addr <= input_address;   // rewind for next line
                                item_cnt <= '0;
                                state    <= bias_next;
                            end else begin
                                bias_done  <= 1'b1;
                                input_done <= 1'b1;
                                state      <= DONE;
                            end
                        end else if (axi_rlast) begin
                            state <= VEC_CMD;   // rest of the line
                        end
                    end
                end
                DONE: begin
                    if (!bias_go) bias_done <= 1'b0;
                    if (!input_go) input_done <= 1'b0;
                    if (!bias_go && !input_go) state <= READY;
                end
                default: state <= IDLE;
            endcase
        end
    end

    assign linear_ready = ready_q & ~linear_init;

    // ------------------------------------------------
    // burst command, steady while in a command state
    assign burst_go = ((state == BIAS_CMD) || (state == VEC_CMD)) & ~cmd_sent;

    always_comb begin
        cmd.is_bias    = (state == BIAS_CMD);
        cmd.addr       = cmd.is_bias ? bias_addr : vec_addr;
        cmd.beats_left = cmd.is_bias ? cnt_t'(1) : (input_size - item_cnt);
    end

    // read data steering
    always_comb begin
        case (state)
            BIAS_DATA: axi_rready = bias_wr_ready;
            VEC_DATA:  axi_rready = vec_wr_ready;
            default:   axi_rready = 1'b0;
        endcase
    end

    assign bias_wr_valid = (state == BIAS_ZERO) | ((state == BIAS_DATA) & axi_rvalid);
    assign bias_wr.data  = (state == BIAS_DATA) ? axi_rdata : '0;
    assign bias_wr.last  = (state == BIAS_DATA) && (bias_cnt == (output_size - cnt_t'(1)));

    assign vec_wr_valid  = (state == VEC_DATA) & axi_rvalid;
    assign vec_wr.data   = axi_rdata;
    assign vec_wr.last   = line_end;   // final item of a line

endmodule

// ==== rtl/lin_input_ctrl_top.sv ====
// Linear layer input fetch top
`timescale 1ns/1ps
`include "lin_params.svh"

module lin_input_ctrl_top (
    input  logic                ACLK,
    input  logic                ARESETn,
    // AXI read address channel
    output lin_pkg::axi_id_t    axi_arid,
    output lin_pkg::addr_t      axi_araddr,
    output lin_pkg::burst_len_t axi_arlen,
    output logic [2:0]          axi_arsize,
    output logic [1:0]          axi_arburst,
    output logic                axi_arvalid,
    input  logic                axi_arready,
    // AXI read data channel
    input  lin_pkg::data_t      axi_rdata,
    input  logic                axi_rlast,
    input  logic                axi_rvalid,
    output logic                axi_rready,
    // bias stream
    input  logic                out_bias_ready,
    output logic                out_bias_valid,
    output lin_pkg::data_t      out_bias_data,
    output logic                out_bias_last,
    // vector stream
    input  logic                out_ready,
    output logic                out_valid,
    output lin_pkg::data_t      out_data,
    output logic                out_last,    // end of a line
    // control
    input  logic                linear_init,
    output logic                linear_ready,
    input  logic                bias_go,
    output logic                bias_done,
    input  lin_pkg::addr_t      bias_address,
    input  lin_pkg::cnt_t       bias_size,
    input  lin_pkg::cnt_t       output_size,
    input  logic                input_go,
    output logic                input_done,
    input  lin_pkg::addr_t      input_address,
    input  lin_pkg::cnt_t       input_size,
    input  lin_pkg::cnt_t       input_num,
    input  lin_pkg::burst_len_t input_leng
);
    import lin_pkg::*;

    logic                      burst_go;
    rd_cmd_t                   cmd;
    logic                      ar_done;
    logic                      bias_wr_valid;
    logic                      bias_wr_ready;
    fifo_word_t                bias_wr;
    fifo_word_t                bias_rd;
    logic                      vec_wr_valid;
    logic                      vec_wr_ready;
    fifo_word_t                vec_wr;
    fifo_word_t                vec_rd;
    logic [`LIN_VEC_FIFO_AW:0] vec_room;

    // ------------------------------------------------
    lin_burst_issuer u_issuer (
        .ACLK        (ACLK),
        .ARESETn     (ARESETn),
        .linear_init (linear_init),
        .burst_go    (burst_go),
        .cmd         (cmd),
        .input_leng  (input_leng),
        .vec_room    (vec_room),
        .axi_arready (axi_arready),
        .axi_arid    (axi_arid),
        .axi_araddr  (axi_araddr),
        .axi_arlen   (axi_arlen),
        .axi_arsize  (axi_arsize),
        .axi_arburst (axi_arburst),
        .axi_arvalid (axi_arvalid),
        .ar_done     (ar_done)
    );

    lin_fetch_seq u_seq (
        .ACLK          (ACLK),
        .ARESETn       (ARESETn),
        .linear_init   (linear_init),
        .bias_go       (bias_go),
        .input_go      (input_go),
        .bias_address  (bias_address),
        .input_address (input_address),
        .bias_size     (bias_size),
        .output_size   (output_size),
        .input_size    (input_size),
        .input_num     (input_num),
        .ar_done       (ar_done),
        .axi_rdata     (axi_rdata),
        .axi_rlast     (axi_rlast),
        .axi_rvalid    (axi_rvalid),
        .bias_wr_ready (bias_wr_ready),
        .vec_wr_ready  (vec_wr_ready),
        .linear_ready  (linear_ready),
        .bias_done     (bias_done),
        .input_done    (input_done),
        .burst_go      (burst_go),
        .cmd           (cmd),
        .axi_rready    (axi_rready),
        .bias_wr_valid (bias_wr_valid),
        .bias_wr       (bias_wr),
        .vec_wr_valid  (vec_wr_valid),
        .vec_wr        (vec_wr)
    );

    // ------------------------------------------------
    // output buffers, both flushed by linear_init
    lin_sync_fifo #(.WIDTH($bits(fifo_word_t)), .AW(`LIN_VEC_FIFO_AW)) u_vec_fifo (
        .ACLK     (ACLK),
        .ARESETn  (ARESETn),
        .clr      (linear_init),
        .wr_valid (vec_wr_valid),
        .wr_data  (vec_wr),
        .wr_ready (vec_wr_ready),
        .rd_valid (out_valid),
        .rd_data  (vec_rd),
        .rd_ready (out_ready),
        .room     (vec_room)
    );

    lin_sync_fifo #(.WIDTH($bits(fifo_word_t)), .AW(`LIN_BIAS_FIFO_AW)) u_bias_fifo (
        .ACLK     (ACLK),
        .ARESETn  (ARESETn),
        .clr      (linear_init),
        .wr_valid (bias_wr_valid),
        .wr_data  (bias_wr),
        .wr_ready (bias_wr_ready),
        .rd_valid (out_bias_valid),
        .rd_data  (bias_rd),
        .rd_ready (out_bias_ready),
        .room     ()
    );

    assign out_data      = vec_rd.data;
    assign out_last      = vec_rd.last;
    assign out_bias_data = bias_rd.data;
    assign out_bias_last = bias_rd.last;

endmodule

// ==== rtl/lin_params.svh ====
// Linear fetch parameters
`ifndef LIN_PARAMS_SVH
`define LIN_PARAMS_SVH

// bus and item widths
`define LIN_ADDR_W        32
`define LIN_DATA_W        32
`define LIN_ID_W          4
`define LIN_CNT_W         16     // size and count fields

// ------------------------------------------------
// buffering
`define LIN_VEC_FIFO_AW   5      // 32 vector entries
`define LIN_BIAS_FIFO_AW  2      // 4 bias entries

// word geometry
`define LIN_WORD_BYTES    4
`define LIN_ARSIZE_WORD   2      // 4 bytes per beat

`endif

// ==== rtl/lin_pkg.sv ====
// Linear fetch types
`include "lin_params.svh"

package lin_pkg;

    typedef logic [`LIN_ADDR_W-1:0] addr_t;
    typedef logic [`LIN_DATA_W-1:0] data_t;
    typedef logic [`LIN_ID_W-1:0]   axi_id_t;
    typedef logic [`LIN_CNT_W-1:0]  cnt_t;
    typedef logic [7:0]             burst_len_t;   // AxLEN format

    // one read burst request
    typedef struct packed {
        addr_t addr;
        cnt_t  beats_left;    // remainder of the line, 1 for bias
        logic  is_bias;
    } rd_cmd_t;

    typedef struct packed {
        data_t data;
        logic  last;
    } fifo_word_t;

    typedef enum logic [3:0] {
        IDLE,
        READY,
        BIAS_CMD,
        BIAS_DATA,
        BIAS_ZERO,
        VEC_CMD,
        VEC_DATA,
        DONE
    } seq_state_t;

endpackage

// ==== rtl/lin_sync_fifo.sv ====
// Synchronous FIFO with room count
`timescale 1ns/1ps

module lin_sync_fifo #(
    parameter int WIDTH = 33,
    parameter int AW    = 5
) (
    input  logic             ACLK,
    input  logic             ARESETn,
    input  logic             clr,
    input  logic             wr_valid,
    input  logic [WIDTH-1:0] wr_data,
    output logic             wr_ready,
    output logic             rd_valid,
    output logic [WIDTH-1:0] rd_data,
    input  logic             rd_ready,
    output logic [AW:0]      room
);

    localparam int DEPTH = 1 << AW;

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW-1:0]    wr_ptr;
    logic [AW-1:0]    rd_ptr;
    logic [AW:0]      count;     // entries held
    logic             push;
    logic             pop;

    assign push = wr_valid & wr_ready;
    assign pop  = rd_valid & rd_ready;

    // ------------------------------------------------
    // pointers and occupancy
    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (clr) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;   // wraps at depth
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // storage
    always_ff @(posedge ACLK) begin
        if (push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // ------------------------------------------------
    assign rd_data  = mem[rd_ptr];   // head entry straight from the array
    assign rd_valid = (count != '0);
    assign wr_ready = (count != (AW+1)'(DEPTH));
    assign room     = (AW+1)'(DEPTH) - count;

endmodule

// ==== verification/lin_input_ctrl_checker.sv ====
// Linear fetch port assertions
`timescale 1ns/1ps
`include "lin_params.svh"

module lin_input_ctrl_checker (
    input logic                      ACLK,
    input logic                      ARESETn,
    input logic                      linear_init,
    input logic                      linear_ready,
    input lin_pkg::axi_id_t          axi_arid,
    input lin_pkg::addr_t            axi_araddr,
    input lin_pkg::burst_len_t       axi_arlen,
    input logic [2:0]                axi_arsize,
    input logic [1:0]                axi_arburst,
    input logic                      axi_arvalid,
    input logic                      axi_arready,
    input logic                      axi_rready,
    input lin_pkg::burst_len_t       input_leng,
    input logic                      is_bias,
    input logic [`LIN_VEC_FIFO_AW:0] vec_room,
    input logic                      out_valid,
    input logic                      out_bias_valid,
    input logic                      bias_go,
    input logic                      input_go,
    input logic                      bias_done,
    input logic                      input_done
);
    import lin_pkg::*;

    int      fail_cnt = 0;   // failed assertions so far
    axi_id_t prev_id;

    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            prev_id <= '0;
        end else if (linear_init) begin
            prev_id <= '0;
        end else if (axi_arvalid && axi_arready) begin
            prev_id <= axi_arid;
        end
    end

    // ------------------------------------------------
    // reset, init and ready timing
    a_reset_idle: assert property (@(posedge ACLK)
        !ARESETn |-> !axi_arvalid && !axi_rready && !out_valid && !out_bias_valid
                     && !bias_done && !input_done && !linear_ready)
        else begin $error("outputs active during reset"); fail_cnt++; end

    a_init_idle: assert property (@(posedge ACLK) disable iff (!ARESETn)
        linear_init |=> !axi_arvalid && !axi_rready && !out_valid && !out_bias_valid
                        && !bias_done && !input_done)
        else begin $error("outputs active after linear_init"); fail_cnt++; end

    a_ready_time: assert property (@(posedge ACLK)
        ($rose(ARESETn) || (ARESETn && $fell(linear_init))) |-> !linear_ready ##1 linear_ready)
        else begin $error("linear_ready not set one cycle after reset or init"); fail_cnt++; end

    // ------------------------------------------------
    // read address channel
    a_burst_form: assert property (@(posedge ACLK) disable iff (!ARESETn || linear_init)
        axi_arvalid |-> axi_arsize == 3'(`LIN_ARSIZE_WORD) && axi_arburst == 2'b01
                        && axi_arlen <= input_leng)
        else begin $error("read request has a wrong size, burst type or length"); fail_cnt++; end

    a_ar_stable: assert property (@(posedge ACLK) disable iff (!ARESETn || linear_init)
        axi_arvalid && !axi_arready |=> axi_arvalid && $stable(axi_araddr)
                                        && $stable(axi_arlen) && $stable(axi_arid))
        else begin $error("read request changed while waiting for ARREADY"); fail_cnt++; end

    a_ar_id: assert property (@(posedge ACLK) disable iff (!ARESETn || linear_init)
        axi_arvalid && axi_arready |-> axi_arid == prev_id + axi_id_t'(1))
        else begin $error("ARID did not advance by one"); fail_cnt++; end

    a_vec_room: assert property (@(posedge ACLK) disable iff (!ARESETn || linear_init)
        axi_arvalid && !is_bias |-> vec_room > axi_arlen)
        else begin $error("vector burst issued without room in the FIFO"); fail_cnt++; end

    // ------------------------------------------------
    // done levels
    a_done_pair: assert property (@(posedge ACLK) disable iff (!ARESETn || linear_init)
        $rose(bias_done) == $rose(input_done))
        else begin $error("done flags did not rise together"); fail_cnt++; end

    a_done_hold: assert property (@(posedge ACLK) disable iff (!ARESETn || linear_init)
        bias_done && input_done && bias_go && input_go |=> bias_done && input_done)
        else begin $error("done dropped while go was still high"); fail_cnt++; end

    a_bias_release: assert property (@(posedge ACLK) disable iff (!ARESETn || linear_init)
        bias_done && !bias_go |=> !bias_done)
        else begin $error("bias_done stayed high after bias_go fell"); fail_cnt++; end

    a_input_release: assert property (@(posedge ACLK) disable iff (!ARESETn || linear_init)
        input_done && !input_go |=> !input_done)
        else begin $error("input_done stayed high after input_go fell"); fail_cnt++; end

endmodule

// ==== verification/tb_lin_input_ctrl.sv ====
// Linear fetch testbench
`timescale 1ns/1ps
`include "lin_params.svh"

module tb_lin_input_ctrl;
    import lin_pkg::*;

    localparam data_t MEM_KEY = 32'hC3A5_1E69;   // memory fill pattern

    logic        ACLK;
    logic        ARESETn;
    axi_id_t     axi_arid;
    addr_t       axi_araddr;
    burst_len_t  axi_arlen;
    logic [2:0]  axi_arsize;
    logic [1:0]  axi_arburst;
    logic        axi_arvalid;
    logic        axi_arready;
    data_t       axi_rdata;
    logic        axi_rlast;
    logic        axi_rvalid;
    logic        axi_rready;
    logic        out_bias_ready;
    logic        out_bias_valid;
    data_t       out_bias_data;
    logic        out_bias_last;
    logic        out_ready;
    logic        out_valid;
    data_t       out_data;
    logic        out_last;
    logic        linear_init;
    logic        linear_ready;
    logic        bias_go;
    logic        bias_done;
    logic        input_go;
    logic        input_done;
    addr_t       bias_address;
    addr_t       input_address;
    cnt_t        bias_size;
    cnt_t        output_size;
    cnt_t        input_size;
    cnt_t        input_num;
    burst_len_t  input_leng;

    integer      seed;
    logic        toggle_ready;    // random back-pressure on both outputs
    logic        stall_out;       // both output readies held low
    logic        r_taken;
    int          r_beat;
    int          vec_cnt;
    int          bias_cnt;
    addr_t       ar_addr_q[$];    // accepted bursts, oldest first
    burst_len_t  ar_len_q[$];

    lin_input_ctrl_top lin_input_ctrl_top_inst (.*);

    bind lin_input_ctrl_top lin_input_ctrl_checker u_checker (.*, .is_bias(cmd.is_bias));

    initial begin
        ACLK = 1'b0;
        forever #20 ACLK = ~ACLK;
    end

    function automatic data_t word_at(input addr_t a);
        return {a[15:0], a[31:16]} ^ MEM_KEY;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    // ------------------------------------------------
    // slave memory model and output back-pressure
    task automatic check_request();
        addr_t line_end;
        addr_t burst_end;
        line_end  = input_address + addr_t'(int'(input_size) * `LIN_WORD_BYTES);
        burst_end = axi_araddr + addr_t'((int'(axi_arlen) + 1) * `LIN_WORD_BYTES);
        if (axi_araddr >= input_address) begin
            assert (burst_end <= line_end) else abort_run($sformatf(
                "Fail axi_araddr %h axi_arlen %h passes line end %h",
                axi_araddr, axi_arlen, line_end));
        end else begin
            assert (axi_arlen == 8'h00) else abort_run($sformatf(
                "Fail axi_arlen got %h exp %h", axi_arlen, 8'h00));
        end
    endtask

    always @(posedge ACLK) begin
        r_taken = axi_rvalid && axi_rready;
        if (!ARESETn || linear_init) begin
            ar_addr_q.delete();
            ar_len_q.delete();
            r_beat  = 0;
            r_taken = 1'b1;
        end else begin
            if (axi_arvalid && axi_arready) begin
                check_request();
                ar_addr_q.push_back(axi_araddr);
                ar_len_q.push_back(axi_arlen);
            end
            if (r_taken) begin
                if (r_beat == int'(ar_len_q[0])) begin
                    ar_addr_q.delete(0);
                    ar_len_q.delete(0);
                    r_beat = 0;
                end else begin
                    r_beat++;
                end
            end
        end
        #2;
        axi_arready    = ($random(seed) & 3) != 0;
        out_ready      = !stall_out && (!toggle_ready || (($random(seed) & 1) != 0));
        out_bias_ready = !stall_out && (!toggle_ready || (($random(seed) & 1) != 0));
        if (r_taken || !axi_rvalid) begin   // R beat held until accepted
            if (ar_addr_q.size() != 0 && ($random(seed) & 3) != 0) begin
                axi_rvalid = 1'b1;
                axi_rdata  = word_at(ar_addr_q[0] + addr_t'(r_beat * `LIN_WORD_BYTES));
                axi_rlast  = (r_beat == int'(ar_len_q[0]));
            end else begin
                axi_rvalid = 1'b0;
            end
        end
    end

    // ------------------------------------------------
    // scoreboard
    task automatic check_vector_item();
        int    pos;
        data_t exp_data;
        logic  exp_last;
        pos      = vec_cnt % int'(input_size);
        exp_data = word_at(input_address + addr_t'(pos * `LIN_WORD_BYTES));
        exp_last = (pos == int'(input_size) - 1);
        assert (vec_cnt < int'(input_size) * int'(input_num))
            else abort_run("vector output delivered more items than the job holds");
        assert (out_data == exp_data)
            else abort_run($sformatf("Fail out_data got %h exp %h", out_data, exp_data));
        assert (out_last == exp_last)
            else abort_run($sformatf("Fail out_last got %h exp %h", out_last, exp_last));
        vec_cnt++;
    endtask

    task automatic check_bias_item();
        data_t exp_data;
        logic  exp_last;
        exp_data = '0;   // zero word when no bias
        if (bias_size != '0) begin
            exp_data = word_at(bias_address + addr_t'(bias_cnt * `LIN_WORD_BYTES));
        end
        exp_last = (bias_size != '0) && (bias_cnt == int'(output_size) - 1);
        assert (bias_cnt < int'(input_num))
            else abort_run("bias output delivered more words than there are lines");
        assert (out_bias_data == exp_data) else abort_run($sformatf(
            "Fail out_bias_data got %h exp %h", out_bias_data, exp_data));
        assert (out_bias_last == exp_last) else abort_run($sformatf(
            "Fail out_bias_last got %h exp %h", out_bias_last, exp_last));
        bias_cnt++;
    endtask

    always @(posedge ACLK) begin
        if (ARESETn && !linear_init) begin
            if (out_valid && out_ready) check_vector_item();
            if (out_bias_valid && out_bias_ready) check_bias_item();
        end
    end

    always @(negedge ACLK) begin
        if (lin_input_ctrl_top_inst.u_checker.fail_cnt != 0) begin
            abort_run("a bound assertion failed");
        end
    end

    // ------------------------------------------------
    // waits, each with its own limit
    task automatic wait_ready();
        int n;
        n = 0;
        while (!linear_ready) begin
            @(negedge ACLK);
            n++;
            if (n > 20) abort_run("timeout waiting for linear_ready");
        end
    endtask

    task automatic wait_flags(input logic level);
        int n;
        n = 0;
        while (bias_done != level || input_done != level) begin
            @(negedge ACLK);
            n++;
            if (n > 5000) abort_run("timeout waiting for the done flags to change");
        end
    endtask

    task automatic wait_outputs(input int total, input int lines);
        int n;
        n = 0;
        while (vec_cnt < total || bias_cnt < lines) begin
            @(negedge ACLK);
            n++;
            if (n > 2000) abort_run("timeout waiting for the output streams to drain");
        end
    endtask

    // job cut short by linear_init while both FIFOs hold items
    task automatic init_mid_job();
        int n;
        n = 0;
        @(posedge ACLK);
        #2;
        stall_out     = 1'b1;
        bias_address  = 32'h0000_3000;
        bias_size     = 16'd3;
        output_size   = 16'd3;
        input_address = 32'h0000_B000;
        input_size    = 16'd20;
        input_num     = 16'd3;
        input_leng    = 8'd7;
        bias_go       = 1'b1;
        input_go      = 1'b1;
        while (!out_valid || !out_bias_valid) begin
            @(negedge ACLK);
            n++;
            if (n > 500) abort_run("timeout waiting for buffered items before linear_init");
        end
        @(posedge ACLK);
        #2;
        linear_init = 1'b1;
        bias_go     = 1'b0;
        input_go    = 1'b0;
        @(posedge ACLK);
        #2;
        linear_init = 1'b0;
        stall_out   = 1'b0;
        wait_ready();
    endtask

    task automatic run_job(input addr_t b_addr, input cnt_t b_size, input addr_t v_addr,
                           input cnt_t v_size, input cnt_t num, input burst_len_t leng);
        @(posedge ACLK);
        #2;
        bias_address  = b_addr;
        bias_size     = b_size;
        output_size   = num;   // last bias on the final line
        input_address = v_addr;
        input_size    = v_size;
        input_num     = num;
        input_leng    = leng;
        vec_cnt       = 0;
        bias_cnt      = 0;
        bias_go       = 1'b1;
        input_go      = 1'b1;
        wait_flags(1'b1);
        wait_outputs(int'(v_size) * int'(num), int'(num));
        repeat (4) @(negedge ACLK);
        assert (!out_valid && !out_bias_valid)
            else abort_run("output FIFO still holds items after the job");
        @(posedge ACLK);
        #2;
        bias_go  = 1'b0;
        input_go = 1'b0;
        wait_flags(1'b0);
    endtask

    // ------------------------------------------------
    initial begin
        seed           = 6843;
        toggle_ready   = 1'b0;
        stall_out      = 1'b0;
        vec_cnt        = 0;
        bias_cnt       = 0;
        ARESETn        = 1'b0;
        linear_init    = 1'b0;
        bias_go        = 1'b0;
        input_go       = 1'b0;
        bias_address   = '0;
        input_address  = '0;
        bias_size      = '0;
        output_size    = '0;
        input_size     = '0;
        input_num      = '0;
        input_leng     = '0;
        axi_arready    = 1'b0;
        axi_rvalid     = 1'b0;
        axi_rdata      = '0;
        axi_rlast      = 1'b0;
        out_ready      = 1'b0;
        out_bias_ready = 1'b0;
        repeat (4) @(posedge ACLK);
        #2;
        ARESETn = 1'b1;
        wait_ready();

        run_job(32'h0000_1000, 16'd3, 32'h0000_8000, 16'd20, 16'd3, 8'd7);
        run_job(32'h0000_1000, 16'd0, 32'h0000_9000, 16'd13, 16'd2, 8'd3);   // zero bias
        toggle_ready = 1'b1;
        run_job(32'h0000_2000, 16'd2, 32'h0000_A000, 16'd40, 16'd2, 8'd15);
        toggle_ready = 1'b0;
        init_mid_job();
        run_job(32'h0000_1000, 16'd3, 32'h0000_8000, 16'd20, 16'd3, 8'd7);

        if (lin_input_ctrl_top_inst.u_checker.fail_cnt == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            abort_run("bound assertion failures were counted");
        end
    end

endmodule

// ==== verilog.f ====
+incdir+rtl
rtl/lin_pkg.sv
rtl/lin_burst_issuer.sv
rtl/lin_fetch_seq.sv
rtl/lin_sync_fifo.sv
rtl/lin_input_ctrl_top.sv
verification/lin_input_ctrl_checker.sv
verification/tb_lin_input_ctrl.sv
